// ==== mem_subsystem.f ====
common/mem_sys_pkg.sv
mem_region/mem_manager.sv
mem_region/region_ram.sv
mem_region/mem_region.sv
src/mem_req_stage.sv
src/mem_read_combiner.sv
src/mem_subsystem.sv
verif/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and grade the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f mem_subsystem.f \
    --top-module mem_subsystem_tb \
    --Mdir "$BUILD_DIR" \
    -o mem_subsystem_sim

# A stop on an RTL assertion exits nonzero, the log is graded either way
"./$BUILD_DIR/mem_subsystem_sim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

// ==== verif/mem_subsystem_tb.sv ====
// Reads only touch words written first, since RAM contents start undefined; checks run on falling edges
`timescale 1ns/100ps

module mem_subsystem_tb;

    import mem_sys_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic [XLEN-1:0]      a_addr;
    logic [XLEN-1:0]      a_wdata;
    logic [NUM_BYTES-1:0] a_byteen;
    logic                 a_rden;
    logic                 a_wren;
    logic                 a_aclr;
    logic [XLEN-1:0]      a_rdata;
    logic                 a_rvalid;
    logic                 a_fault;
    logic [XLEN-1:0]      b_addr;
    logic                 b_rden;
    logic [XLEN-1:0]      b_rdata;
    logic                 b_rvalid;
    logic                 b_fault;

    // Reference memory, keyed by flat word address
    logic [XLEN-1:0] model [logic [XLEN-1:0]];

    // Expected results per port, slot 0 newest, slot 3 due at the outputs
    logic [3:0]      exp_av;
    logic [3:0]      exp_af;
    logic [3:0]      exp_bv;
    logic [3:0]      exp_bf;
    logic [XLEN-1:0] exp_ad [4];
    logic [XLEN-1:0] exp_bd [4];

    int    err_data;
    int    err_ctrl;
    int    err_timeout;
    string test_name;

    // Offsets at both ends and the middle of a region
    logic [ADDR_BITS-1:0] edge_off [3] = '{10'd0, 10'd512, 10'd1023};
    // Word pool for random traffic
    logic [ADDR_BITS-1:0] pool_off [8] = '{10'd0, 10'd1, 10'd2, 10'd511,
                                           10'd512, 10'd1021, 10'd1022, 10'd1023};
    // Identifiers that no region owns
    logic [ID_WIDTH-1:0]  bad_id [4] = '{22'h000002, 22'h000200, 22'h3FFFFE, 22'h123456};

    mem_subsystem u_mem_subsystem (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Selector 0 to 3 picks a mapped region, 4 to 7 an unmapped identifier
    function automatic logic [XLEN-1:0] pick_addr(input logic [2:0] sel,
                                                  input logic [ADDR_BITS-1:0] off);
        mem_addr_u u;
        u.fld.region_id = sel[2] ? bad_id[sel[1:0]] : REGION_ID[sel[1:0]];
        u.fld.offset    = off;
        return u.word;
    endfunction

    function automatic logic is_mapped(input logic [XLEN-1:0] addr);
        mem_addr_u u;
        logic      hit;
        u.word = addr;
        hit    = 1'b0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            if (u.fld.region_id == REGION_ID[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Fill pattern built from every address bit
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
    endfunction

    // Lane-wise merge of new bytes over the old word
    function automatic logic [XLEN-1:0] merge_bytes(input logic [XLEN-1:0] old_w,
                                                    input logic [XLEN-1:0] new_w,
                                                    input logic [NUM_BYTES-1:0] be);
        logic [XLEN-1:0] res;
        res = old_w;
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // Outcome of a read issued now, before this cycle's write lands
    task automatic predict_read(input logic [XLEN-1:0] addr, output logic v, output logic f,
                                output logic [XLEN-1:0] d);
        v = is_mapped(addr);
        f = ~v;
        d = '0;
        // Clear level zeroes the RAM read registers of both ports
        if (v && !a_aclr) begin
            d = model.exists(addr) ? model[addr] : '0;
        end
    endtask

    // Drive one cycle of requests, update the model, then move to the next drive point
    task automatic do_cycle(input logic ard, input logic awr, input logic [XLEN-1:0] aaddr,
                            input logic [XLEN-1:0] awdata, input logic [NUM_BYTES-1:0] abe,
                            input logic brd, input logic [XLEN-1:0] baddr);
        logic            av;
        logic            af;
        logic            bv;
        logic            bf;
        logic [XLEN-1:0] ad;
        logic [XLEN-1:0] bd;
        a_rden   = ard;
        a_wren   = awr;
        a_addr   = aaddr;
        a_wdata  = awdata;
        a_byteen = abe;
        b_rden   = brd;
        b_addr   = baddr;
        predict_read(aaddr, av, af, ad);
        predict_read(baddr, bv, bf, bd);
        // Age the expectations by one cycle
        for (int i = 3; i > 0; i--) begin
            exp_ad[i] = exp_ad[i-1];
            exp_bd[i] = exp_bd[i-1];
        end
        exp_av    = {exp_av[2:0], ard & av};
        exp_af    = {exp_af[2:0], ard & af};
        exp_ad[0] = ard ? ad : '0;
        exp_bv    = {exp_bv[2:0], brd & bv};
        exp_bf    = {exp_bf[2:0], brd & bf};
        exp_bd[0] = brd ? bd : '0;
        // Unmapped writes vanish
        if (awr && is_mapped(aaddr)) begin
            model[aaddr] = merge_bytes(model.exists(aaddr) ? model[aaddr] : '0, awdata, abe);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic idle_cycle();
        do_cycle(1'b0, 1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic write_a(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data,
                           input logic [NUM_BYTES-1:0] be);
        do_cycle(1'b0, 1'b1, addr, data, be, 1'b0, '0);
    endtask

    task automatic read_a(input logic [XLEN-1:0] addr);
        do_cycle(1'b1, 1'b0, addr, '0, '0, 1'b0, '0);
    endtask

    task automatic read_b(input logic [XLEN-1:0] addr);
        do_cycle(1'b0, 1'b0, '0, '0, '0, 1'b1, addr);
    endtask

    // Idle until every issued read has been checked
    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while ((|{exp_av, exp_af, exp_bv, exp_bf}) && cnt < 16) begin
            idle_cycle();
            cnt++;
        end
        if (|{exp_av, exp_af, exp_bv, exp_bf}) begin
            err_timeout++;
            $display("Timeout: reads still in flight at the end of %s", test_name);
        end
    endtask

    // Outputs settle after the rising edge, compare at the falling edge
    a_data_chk: assert property (@(negedge clk) disable iff (!rst_n) a_rdata == exp_ad[3])
        else begin
            err_data++;
            $display("** Error %s: a_rdata expected %h actual %h", test_name, exp_ad[3], a_rdata);
        end

    a_ctrl_chk: assert property (@(negedge clk) disable iff (!rst_n)
        {a_rvalid, a_fault} == {exp_av[3], exp_af[3]})
        else begin
            err_ctrl++;
            $display("** Error %s: a_rvalid,a_fault expected %b actual %b", test_name,
                     {exp_av[3], exp_af[3]}, {a_rvalid, a_fault});
        end

    b_data_chk: assert property (@(negedge clk) disable iff (!rst_n) b_rdata == exp_bd[3])
        else begin
            err_data++;
            $display("** Error %s: b_rdata expected %h actual %h", test_name, exp_bd[3], b_rdata);
        end

    b_ctrl_chk: assert property (@(negedge clk) disable iff (!rst_n)
        {b_rvalid, b_fault} == {exp_bv[3], exp_bf[3]})
        else begin
            err_ctrl++;
            $display("** Error %s: b_rvalid,b_fault expected %b actual %b", test_name,
                     {exp_bv[3], exp_bf[3]}, {b_rvalid, b_fault});
        end

    initial begin
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] rnd;
        void'($urandom(32'h5deb));
        rst_n       = 1'b0;
        a_aclr      = 1'b0;
        exp_av      = '0;
        exp_af      = '0;
        exp_bv      = '0;
        exp_bf      = '0;
        err_data    = 0;
        err_ctrl    = 0;
        err_timeout = 0;
        for (int i = 0; i < 4; i++) begin
            exp_ad[i] = '0;
            exp_bd[i] = '0;
        end
        test_name = "reset";
        for (int i = 0; i < 16; i++) begin
            idle_cycle();
        end
        rst_n = 1'b1;

        // Full words at both ends and the middle of each region
        test_name = "full_word";
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 3; k++) begin
                addr = pick_addr(3'(r), edge_off[k]);
                write_a(addr, fill_word(addr), 4'hF);
                read_a(addr);
                idle_cycle();
            end
        end
        wait_drain();

        // Random lane masks over a known word
        test_name = "byte_enable";
        for (int r = 0; r < 4; r++) begin
            addr = pick_addr(3'(r), 10'd77);
            write_a(addr, fill_word(addr), 4'hF);
            for (int j = 0; j < 3; j++) begin
                rnd = $urandom();
                write_a(addr, rnd, rnd[31:28]);
                read_a(addr);
            end
        end
        wait_drain();

        test_name = "port_b";
        for (int r = 0; r < 4; r++) begin
            addr = pick_addr(3'(r), 10'd300);
            write_a(addr, fill_word(addr), 4'hF);
            // Fetch in the write cycle sees the old word, one cycle later the new one
            do_cycle(1'b0, 1'b1, addr, fill_word(addr) ^ 32'hFFFF_0000, 4'hF, 1'b1, addr);
            read_b(addr);
        end
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 3; k++) begin
                read_b(pick_addr(3'(r), edge_off[k]));
            end
        end
        wait_drain();

        test_name = "unmapped";
        for (int r = 4; r < 8; r++) begin
            do_cycle(1'b1, 1'b0, pick_addr(3'(r), 10'd512), '0, '0,
                     1'b1, pick_addr(3'(r), 10'd7));
        end
        // Same offset as the region 0 word, which must keep its value
        write_a(pick_addr(3'd4, 10'd512), 32'hDEAD_BEEF, 4'hF);
        read_a(pick_addr(3'd0, 10'd512));
        read_b(pick_addr(3'd0, 10'd512));
        wait_drain();

        test_name = "aclr";
        a_aclr = 1'b1;
        for (int r = 0; r < 4; r++) begin
            do_cycle(1'b1, 1'b0, pick_addr(3'(r), 10'd0), '0, '0,
                     1'b1, pick_addr(3'(r), 10'd1023));
        end
        a_aclr = 1'b0;
        for (int r = 0; r < 4; r++) begin
            do_cycle(1'b1, 1'b0, pick_addr(3'(r), 10'd0), '0, '0,
                     1'b1, pick_addr(3'(r), 10'd1023));
        end
        wait_drain();

        test_name = "random";
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 8; k++) begin
                addr = pick_addr(3'(r), pool_off[k]);
                write_a(addr, fill_word(addr), 4'hF);
            end
        end
        for (int n = 0; n < 400; n++) begin
            rnd    = $urandom();
            a_aclr = (rnd[31:27] == 5'd0);
            // Port A never reads and writes in one cycle
            do_cycle(rnd[0] & ~rnd[1], rnd[1], pick_addr(rnd[4:2], pool_off[rnd[7:5]]),
                     $urandom(), rnd[11:8], rnd[12], pick_addr(rnd[15:13], pool_off[rnd[18:16]]));
        end
        a_aclr = 1'b0;
        wait_drain();

        test_name = "end";
        $display("Errors: data %0d, control %0d, timeout %0d", err_data, err_ctrl, err_timeout);
        if (err_data + err_ctrl + err_timeout == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== src/mem_subsystem.sv ====
// Read latency is three cycles on both ports; no back-pressure, writes to unmapped addresses are dropped
`timescale 1ns/100ps

module mem_subsystem (
    input  logic                              clk,
    input  logic                              rst_n,

    // Port A, data
    input  logic [mem_sys_pkg::XLEN-1:0]      a_addr,
    input  logic [mem_sys_pkg::XLEN-1:0]      a_wdata,
    input  logic [mem_sys_pkg::NUM_BYTES-1:0] a_byteen,
    input  logic                              a_rden,
    input  logic                              a_wren,
    input  logic                              a_aclr,
    output logic [mem_sys_pkg::XLEN-1:0]      a_rdata,
    output logic                              a_rvalid,
    output logic                              a_fault,

    // Port B, instruction fetch
    input  logic [mem_sys_pkg::XLEN-1:0]      b_addr,
    input  logic                              b_rden,
    output logic [mem_sys_pkg::XLEN-1:0]      b_rdata,
    output logic                              b_rvalid,
    output logic                              b_fault
);

    import mem_sys_pkg::*;

    // Request stage outputs
    mem_addr_u            q_a_addr;
    logic [XLEN-1:0]      q_a_wdata;
    logic [NUM_BYTES-1:0] q_a_byteen;
    logic                 q_a_rden;
    logic                 q_a_wren;
    logic                 q_a_aclr;
    mem_addr_u            q_b_addr;
    logic                 q_b_rden;
    logic                 a_rd_pend;
    logic                 b_rd_pend;

    // Region results
    logic [XLEN-1:0]        rdata_a [NUM_REGIONS];
    logic [NUM_REGIONS-1:0] hit_a;
    logic [XLEN-1:0]        rdata_b [NUM_REGIONS];
    logic [NUM_REGIONS-1:0] hit_b;

    mem_req_stage u_mem_req_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .a_addr     (a_addr),
        .a_wdata    (a_wdata),
        .a_byteen   (a_byteen),
        .a_rden     (a_rden),
        .a_wren     (a_wren),
        .a_aclr     (a_aclr),
        .b_addr     (b_addr),
        .b_rden     (b_rden),
        .q_a_addr   (q_a_addr),
        .q_a_wdata  (q_a_wdata),
        .q_a_byteen (q_a_byteen),
        .q_a_rden   (q_a_rden),
        .q_a_wren   (q_a_wren),
        .q_a_aclr   (q_a_aclr),
        .q_b_addr   (q_b_addr),
        .q_b_rden   (q_b_rden),
        .a_rd_pend  (a_rd_pend),
        .b_rd_pend  (b_rd_pend)
    );

    // One region per identifier, all fed the same request
    for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_region
        mem_region #(
            .REGION_IDX (i)
        ) u_mem_region (
            .clk        (clk),
            .rst_n      (rst_n),
            .q_a_addr   (q_a_addr),
            .q_a_wdata  (q_a_wdata),
            .q_a_byteen (q_a_byteen),
            .q_a_rden   (q_a_rden),
            .q_a_wren   (q_a_wren),
            .q_a_aclr   (q_a_aclr),
            .q_b_addr   (q_b_addr),
            .q_b_rden   (q_b_rden),
            .rdata_a    (rdata_a[i]),
            .hit_a      (hit_a[i]),
            .rdata_b    (rdata_b[i]),
            .hit_b      (hit_b[i])
        );
    end

    mem_read_combiner u_mem_read_combiner (
        .clk       (clk),
        .rst_n     (rst_n),
        .rdata_a   (rdata_a),
        .hit_a     (hit_a),
        .rdata_b   (rdata_b),
        .hit_b     (hit_b),
        .a_rd_pend (a_rd_pend),
        .b_rd_pend (b_rd_pend),
        .a_rdata   (a_rdata),
        .a_rvalid  (a_rvalid),
        .a_fault   (a_fault),
        .b_rdata   (b_rdata),
        .b_rvalid  (b_rvalid),
        .b_fault   (b_fault)
    );

endmodule

// ==== src/mem_read_combiner.sv ====
// Region outputs must be zero when not hit; at most one region may claim a read
`timescale 1ns/100ps

module mem_read_combiner (
    input  logic                                clk,
    input  logic                                rst_n,

    // Per-region read data and hit flags
    input  logic [mem_sys_pkg::XLEN-1:0]        rdata_a [mem_sys_pkg::NUM_REGIONS],
    input  logic [mem_sys_pkg::NUM_REGIONS-1:0] hit_a,
    input  logic [mem_sys_pkg::XLEN-1:0]        rdata_b [mem_sys_pkg::NUM_REGIONS],
    input  logic [mem_sys_pkg::NUM_REGIONS-1:0] hit_b,

    // Reads issued, aligned with the region data
    input  logic                                a_rd_pend,
    input  logic                                b_rd_pend,

    output logic [mem_sys_pkg::XLEN-1:0]        a_rdata,
    output logic                                a_rvalid,
    output logic                                a_fault,
    output logic [mem_sys_pkg::XLEN-1:0]        b_rdata,
    output logic                                b_rvalid,
    output logic                                b_fault
);

    import mem_sys_pkg::*;

    logic [XLEN-1:0] or_data_a;
    logic [XLEN-1:0] or_data_b;

    // OR tree, unselected regions contribute zero
    always_comb begin
        or_data_a = '0;
        or_data_b = '0;
        for (int i = 0; i < NUM_REGIONS; i++) begin
            or_data_a = or_data_a | rdata_a[i];
            or_data_b = or_data_b | rdata_b[i];
        end
    end

    // Output register
    // A pending read that no region claimed becomes a fault
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_rdata  <= '0;
            a_rvalid <= 1'b0;
            a_fault  <= 1'b0;
            b_rdata  <= '0;
            b_rvalid <= 1'b0;
            b_fault  <= 1'b0;
        end else begin
            a_rdata  <= or_data_a;
            a_rvalid <= |hit_a;
            a_fault  <= a_rd_pend & ~(|hit_a);
            b_rdata  <= or_data_b;
            b_rvalid <= |hit_b;
            b_fault  <= b_rd_pend & ~(|hit_b);
        end
    end

    // Region identifiers are distinct, so hits never overlap
    hit_onehot: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(hit_a) && $onehot0(hit_b)
    ) else $error("mem_read_combiner: more than one region hit");

    // Every hit traces back to a read the request stage saw
    hit_has_pend: assert property (
        @(posedge clk) disable iff (!rst_n)
            ((|hit_a) -> a_rd_pend) && ((|hit_b) -> b_rd_pend)
    ) else $error("mem_read_combiner: region hit without pending read");

endmodule

// ==== src/mem_req_stage.sv ====
// Input register for both ports; a_rden and a_wren must never be issued in the same cycle
`timescale 1ns/100ps

module mem_req_stage (
    input  logic                              clk,
    input  logic                              rst_n,

    // Raw requests
    input  logic [mem_sys_pkg::XLEN-1:0]      a_addr,
    input  logic [mem_sys_pkg::XLEN-1:0]      a_wdata,
    input  logic [mem_sys_pkg::NUM_BYTES-1:0] a_byteen,
    input  logic                              a_rden,
    input  logic                              a_wren,
    input  logic                              a_aclr,
    input  logic [mem_sys_pkg::XLEN-1:0]      b_addr,
    input  logic                              b_rden,

    // Registered requests
    output mem_sys_pkg::mem_addr_u            q_a_addr,
    output logic [mem_sys_pkg::XLEN-1:0]      q_a_wdata,
    output logic [mem_sys_pkg::NUM_BYTES-1:0] q_a_byteen,
    output logic                              q_a_rden,
    output logic                              q_a_wren,
    output logic                              q_a_aclr,
    output mem_sys_pkg::mem_addr_u            q_b_addr,
    output logic                              q_b_rden,

    // Reads whose data is now in the RAM read registers
    output logic                              a_rd_pend,
    output logic                              b_rd_pend
);

    import mem_sys_pkg::*;

    // Address and write payload
    always_ff @(posedge clk) begin
        q_a_addr.word <= a_addr;
        q_a_wdata     <= a_wdata;
        q_a_byteen    <= a_byteen;
        q_b_addr.word <= b_addr;
    end

    // Strobes, clear level and pending markers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_a_rden  <= 1'b0;
            q_a_wren  <= 1'b0;
            q_a_aclr  <= 1'b0;
            q_b_rden  <= 1'b0;
            a_rd_pend <= 1'b0;
            b_rd_pend <= 1'b0;
        end else begin
            q_a_rden  <= a_rden;
            q_a_wren  <= a_wren;
            q_a_aclr  <= a_aclr;
            q_b_rden  <= b_rden;
            // One more stage to meet the RAM read data
            a_rd_pend <= q_a_rden;
            b_rd_pend <= q_b_rden;
        end
    end

    // Port A carries one operation per cycle
    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n) !(a_rden && a_wren)
    ) else $error("mem_req_stage: a_rden and a_wren issued together");

endmodule

// ==== mem_region/mem_region.sv ====
// One address region; rdata is zero unless this region served the read, hits trail the strobe by one cycle
`timescale 1ns/100ps

module mem_region #(
    parameter int REGION_IDX = 0
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // Registered requests, shared by all regions
    input  mem_sys_pkg::mem_addr_u            q_a_addr,
    input  logic [mem_sys_pkg::XLEN-1:0]      q_a_wdata,
    input  logic [mem_sys_pkg::NUM_BYTES-1:0] q_a_byteen,
    input  logic                              q_a_rden,
    input  logic                              q_a_wren,
    input  logic                              q_a_aclr,
    input  mem_sys_pkg::mem_addr_u            q_b_addr,
    input  logic                              q_b_rden,

    // Read results toward the combiner
    output logic [mem_sys_pkg::XLEN-1:0]      rdata_a,
    output logic                              hit_a,
    output logic [mem_sys_pkg::XLEN-1:0]      rdata_b,
    output logic                              hit_b
);

    import mem_sys_pkg::*;

    // Gated controls between manager and RAM
    logic [XLEN-1:0]      g_a_wdata;
    logic [NUM_BYTES-1:0] g_a_byteen;
    logic [ADDR_BITS-1:0] g_a_addr;
    logic                 g_a_aclr;
    logic                 g_a_rden;
    logic                 g_a_wren;
    logic [ADDR_BITS-1:0] g_b_addr;
    logic                 g_b_rden;

    mem_manager #(
        .ID_BITS (REGION_ID[REGION_IDX])
    ) u_mem_manager (
        .data_in_a    (q_a_wdata),
        .data_out_a   (g_a_wdata),
        .byteen_in_a  (q_a_byteen),
        .byteen_out_a (g_a_byteen),
        .addr_in_a    (q_a_addr),
        .addr_out_a   (g_a_addr),
        .aclr_in_a    (q_a_aclr),
        .aclr_out_a   (g_a_aclr),
        .enable_out_a (),
        .rden_in_a    (q_a_rden),
        .rden_out_a   (g_a_rden),
        .wren_in_a    (q_a_wren),
        .wren_out_a   (g_a_wren),
        // Port B never writes, its data lane idles at zero
        .data_in_b    ('0),
        .data_out_b   (),
        .addr_in_b    (q_b_addr),
        .addr_out_b   (g_b_addr),
        .rden_in_b    (q_b_rden),
        .rden_out_b   (g_b_rden)
    );

    region_ram u_region_ram (
        .clk       (clk),
        .wr_data_a (g_a_wdata),
        .byteen_a  (g_a_byteen),
        .addr_a    (g_a_addr),
        .aclr      (g_a_aclr),
        .rden_a    (g_a_rden),
        .wren_a    (g_a_wren),
        .rd_data_a (rdata_a),
        .addr_b    (g_b_addr),
        .rden_b    (g_b_rden),
        .rd_data_b (rdata_b)
    );

    // Hit flags ride alongside the RAM read register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_a <= 1'b0;
            hit_b <= 1'b0;
        end else begin
            hit_a <= g_a_rden;
            hit_b <= g_b_rden;
        end
    end

endmodule

// ==== mem_region/region_ram.sv ====
// 1024-word dual-port RAM, contents are not reset and not preloaded; read registers read zero when idle
`timescale 1ns/100ps

module region_ram (
    input  logic                              clk,

    // Port A, byte-enabled write and read
    input  logic [mem_sys_pkg::XLEN-1:0]      wr_data_a,
    input  logic [mem_sys_pkg::NUM_BYTES-1:0] byteen_a,
    input  logic [mem_sys_pkg::ADDR_BITS-1:0] addr_a,
    input  logic                              aclr,
    input  logic                              rden_a,
    input  logic                              wren_a,
    output logic [mem_sys_pkg::XLEN-1:0]      rd_data_a,

    // Port B, read only
    input  logic [mem_sys_pkg::ADDR_BITS-1:0] addr_b,
    input  logic                              rden_b,
    output logic [mem_sys_pkg::XLEN-1:0]      rd_data_b
);

    import mem_sys_pkg::*;

    // Word storage
    logic [XLEN-1:0] mem [2**ADDR_BITS];

    // Lane-wise write, untouched lanes keep their old byte
    always_ff @(posedge clk) begin
        if (wren_a) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (byteen_a[i]) begin
                    mem[addr_a][8*i +: 8] <= wr_data_a[8*i +: 8];
                end
            end
        end
    end

    // Port A read register
    // Holds zero unless a read hit this region, so the outputs can be ORed
    always_ff @(posedge clk) begin
        if (aclr) begin
            rd_data_a <= '0;
        end else if (rden_a) begin
            rd_data_a <= mem[addr_a];
        end else begin
            rd_data_a <= '0;
        end
    end

    // Port B read register, same zero-when-idle rule
    // A port B read one edge after a port A write sees the new word
    always_ff @(posedge clk) begin
        if (aclr) begin
            rd_data_b <= '0;
        end else if (rden_b) begin
            rd_data_b <= mem[addr_b];
        end else begin
            rd_data_b <= '0;
        end
    end

endmodule

// ==== mem_region/mem_manager.sv ====
// Purely combinational decode; a_wren and byte enables reach the RAM only when the address hits ID_BITS
`timescale 1ns/100ps

module mem_manager #(
    parameter logic [mem_sys_pkg::ID_WIDTH-1:0] ID_BITS = '0
) (
    // Port A, read and write
    input  logic [mem_sys_pkg::XLEN-1:0]      data_in_a,
    output logic [mem_sys_pkg::XLEN-1:0]      data_out_a,
    input  logic [mem_sys_pkg::NUM_BYTES-1:0] byteen_in_a,
    output logic [mem_sys_pkg::NUM_BYTES-1:0] byteen_out_a,
    input  mem_sys_pkg::mem_addr_u            addr_in_a,
    output logic [mem_sys_pkg::ADDR_BITS-1:0] addr_out_a,
    input  logic                              aclr_in_a,
    output logic                              aclr_out_a,
    output logic                              enable_out_a,
    input  logic                              rden_in_a,
    output logic                              rden_out_a,
    input  logic                              wren_in_a,
    output logic                              wren_out_a,

    // Port B, instruction fetch
    input  logic [mem_sys_pkg::XLEN-1:0]      data_in_b,
    output logic [mem_sys_pkg::XLEN-1:0]      data_out_b,
    input  mem_sys_pkg::mem_addr_u            addr_in_b,
    output logic [mem_sys_pkg::ADDR_BITS-1:0] addr_out_b,
    input  logic                              rden_in_b,
    output logic                              rden_out_b
);

    import mem_sys_pkg::*;

    logic select_a;
    logic select_b;

    // Region match on the upper address field
    assign select_a = (addr_in_a.fld.region_id == ID_BITS);
    assign select_b = (addr_in_b.fld.region_id == ID_BITS);

    // Offset goes to the RAM whether or not selected
    assign addr_out_a = addr_in_a.fld.offset;
    assign addr_out_b = addr_in_b.fld.offset;

    // Port A strobes only fire inside this region
    assign enable_out_a = select_a;
    assign rden_out_a   = select_a & rden_in_a;
    assign wren_out_a   = select_a & wren_in_a;

    // Clear applies to every region alike
    assign aclr_out_a = aclr_in_a;

    // Zero the payload outside the region
    assign byteen_out_a = select_a ? byteen_in_a : '0;
    assign data_out_a   = select_a ? data_in_a : '0;

    assign rden_out_b = select_b & rden_in_b;
    assign data_out_b = select_b ? data_in_b : '0;

endmodule

// ==== common/mem_sys_pkg.sv ====
// Four fixed regions of 1024 words each; region identifiers must stay distinct and unmapped ones fault on read
package mem_sys_pkg;

    // Data and address word width
    localparam int XLEN = 32;

    // One enable per byte lane
    localparam int NUM_BYTES = XLEN / 8;

    // Word offset bits seen by a region RAM
    localparam int ADDR_BITS = 10;

    // Upper address bits that pick the region
    localparam int ID_WIDTH = XLEN - ADDR_BITS;

    localparam int NUM_REGIONS = 4;

    // Region identifiers, entry i belongs to region i
    // 0 and 1 sit at the bottom of the map, 3 holds the top 4 KB
    localparam logic [NUM_REGIONS-1:0][ID_WIDTH-1:0] REGION_ID = {
        22'h3FFFFF,
        22'h000100,
        22'h000001,
        22'h000000
    };

    // Word address, seen either flat or split into region and offset
    typedef union packed {
        logic [XLEN-1:0] word;
        struct packed {
            logic [ID_WIDTH-1:0]  region_id;
            logic [ADDR_BITS-1:0] offset;
        } fld;
    } mem_addr_u;

endpackage
